// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the register file testbench with verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_frf -o tb_frf \
	> build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_frf > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== src/frf_pkg.sv ====
// register file constants, index and enable types, write port control struct.

package frf_pkg;

	// architectural floating-point registers.
	localparam int FREG_NUM = 32;
	localparam int FREG_IDX_W = 5;

	// data width used when the top level does not set one.
	localparam int FLEN_DEFAULT = 64;

	// names one register.
	typedef logic [FREG_IDX_W-1:0] freg_idx_t;

	// one bit per register.
	typedef logic [FREG_NUM-1:0] freg_onehot_t;

	// control half of a write port, the data travels beside it.
	// a set cancel squashes the write even with we high.
	typedef struct packed {
		logic      we;
		logic      cancel;
		freg_idx_t addr;
	} freg_wr_ctl_t;

endpackage

// ==== src/frf_storage.sv ====
// register array with enabled update, synchronous clear and the read multiplexers.

`timescale 1ns/1ns

module frf_storage #(
	parameter int flen = frf_pkg::FLEN_DEFAULT,
	parameter int num_read = 4
) (
	input  logic                  core_clk,
	input  logic                  rst,
	input  frf_pkg::freg_onehot_t wr_en,
	input  logic [flen-1:0]       wr_next [frf_pkg::FREG_NUM],
	input  frf_pkg::freg_idx_t    rd_addr [num_read],
	output logic [flen-1:0]       rd_data [num_read]
);

	logic [flen-1:0] regs [frf_pkg::FREG_NUM];

	// each register loads its merged word when enabled.
	// rst wins over any write in the same cycle.
	always_ff @(posedge core_clk) begin
		for (int g = 0; g < frf_pkg::FREG_NUM; g++) begin
			if (rst) begin
				regs[g] <= '0;
			end else if (wr_en[g]) begin
				regs[g] <= wr_next[g];
			end
		end
	end

	// read ports are plain muxes on the stored value.
	// a write shows up one cycle later, no bypass.
	for (genvar r = 0; r < num_read; r++) begin : g_rd
		assign rd_data[r] = regs[rd_addr[r]];

		// the cycle after a clear, any address reads zero.
		a_clear_reads_zero: assert property (
			@(posedge core_clk) rst |=> (rd_data[r] == '0)
		) else $error("frf: read port %0d returns %h after clear",
			r, rd_data[r]);
	end

endmodule

// ==== src/frf_top.sv ====
// floating-point register file top with write merge and storage.

`timescale 1ns/1ns

module frf_top #(
	parameter int flen = frf_pkg::FLEN_DEFAULT,
	parameter int num_read = 4,
	parameter int num_write = 3
) (
	input  logic                  core_clk,
	input  logic                  rst,
	input  logic                  rf_init,
	input  frf_pkg::freg_wr_ctl_t wr_ctl [num_write],
	input  logic [flen-1:0]       wr_data [num_write],
	input  frf_pkg::freg_idx_t    rd_addr [num_read],
	output logic [flen-1:0]       rd_data [num_read]
);

	// per-register enable and next value from the merge.
	frf_pkg::freg_onehot_t wr_en;
	logic [flen-1:0]       wr_next [frf_pkg::FREG_NUM];

	// only single and double precision widths are built.
	if (flen != 32 && flen != 64) begin : g_bad_flen
		$error("frf_top: flen %0d not supported, use 32 or 64", flen);
	end

	if (num_read < 1 || num_write < 1) begin : g_bad_ports
		$error("frf_top: needs at least one read and one write port");
	end

	frf_write_merge #(
		.flen      (flen),
		.num_write (num_write)
	) u_merge (
		.core_clk (core_clk),
		.rf_init  (rf_init),
		.wr_ctl   (wr_ctl),
		.wr_data  (wr_data),
		.wr_en    (wr_en),
		.wr_next  (wr_next)
	);

	frf_storage #(
		.flen     (flen),
		.num_read (num_read)
	) u_storage (
		.core_clk (core_clk),
		.rst      (rst),
		.wr_en    (wr_en),
		.wr_next  (wr_next),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

endmodule

// ==== src/frf_write_merge.sv ====
// write port decode, per-register write enables and or-merge of the write data.

`timescale 1ns/1ns

module frf_write_merge #(
	parameter int flen = frf_pkg::FLEN_DEFAULT,
	parameter int num_write = 3
) (
	input  logic                  core_clk,
	input  logic                  rf_init,
	input  frf_pkg::freg_wr_ctl_t wr_ctl [num_write],
	input  logic [flen-1:0]       wr_data [num_write],
	output frf_pkg::freg_onehot_t wr_en,
	output logic [flen-1:0]       wr_next [frf_pkg::FREG_NUM]
);

	// port p is active when enabled and not squashed.
	logic [num_write-1:0] port_act;

	// one-hot target of each active port, zero for an idle port.
	frf_pkg::freg_onehot_t hit [num_write];

	// registers hit by at least one port, and by more than one.
	frf_pkg::freg_onehot_t seen;
	frf_pkg::freg_onehot_t multi_hit;

	always_comb begin
		for (int p = 0; p < num_write; p++) begin
			port_act[p] = wr_ctl[p].we & ~wr_ctl[p].cancel;
		end
	end

	// decode by shifting the active bit up to the target index.
	always_comb begin
		for (int p = 0; p < num_write; p++) begin
			hit[p] = frf_pkg::freg_onehot_t'(port_act[p]) << wr_ctl[p].addr;
		end
	end

	// rf_init opens every register, so unwritten ones load zero.
	always_comb begin
		wr_en = {frf_pkg::FREG_NUM{rf_init}};
		for (int p = 0; p < num_write; p++) begin
			wr_en = wr_en | hit[p];
		end
	end

	// and-or merge per register.
	// colliding ports end up or-ed together.
	always_comb begin
		for (int g = 0; g < frf_pkg::FREG_NUM; g++) begin
			wr_next[g] = '0;
			for (int p = 0; p < num_write; p++) begin
				wr_next[g] = wr_next[g] | ({flen{hit[p][g]}} & wr_data[p]);
			end
		end
	end

	// running or of the hits finds the registers claimed twice.
	always_comb begin
		seen = '0;
		multi_hit = '0;
		for (int p = 0; p < num_write; p++) begin
			multi_hit = multi_hit | (seen & hit[p]);
			seen = seen | hit[p];
		end
	end

	// two live writes to one register usually mean an upstream
	// scheduling slip; the merge still stores the or.
	a_write_collision: assert property (
		@(posedge core_clk) !rf_init |-> (multi_hit == '0)
	) else $warning("frf: %0d ports collide on regs %h, data or-merged",
		$countones(port_act), multi_hit);

endmodule

// ==== test/tb_frf_model.svh ====
// reference register model, expected read function and lcg random source.

`ifndef TB_FRF_MODEL_SVH
`define TB_FRF_MODEL_SVH

// model copy of the architectural registers.
logic [tb_flen-1:0] model_regs [frf_pkg::FREG_NUM];

// random state, advanced only through next_rand.
logic [31:0] rand_state = 32'h6322;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] next_rand();
	rand_state = lcg_next(rand_state);
	return rand_state;
endfunction

// expected read data for one address.
function automatic logic [tb_flen-1:0] expected_read(input frf_pkg::freg_idx_t addr);
	return model_regs[addr];
endfunction

// one clock edge of the register file rules.
// a register is touched by rf_init or by any live port aimed at it,
// and a touched register takes the or of the live data aimed at it.
task automatic model_clock();
	logic [tb_flen-1:0] merged;
	logic               touched;
	if (rst) begin
		for (int g = 0; g < frf_pkg::FREG_NUM; g++) begin
			model_regs[g] = '0;
		end
	end else begin
		for (int g = 0; g < frf_pkg::FREG_NUM; g++) begin
			merged = '0;
			touched = rf_init;
			for (int p = 0; p < tb_num_write; p++) begin
				if (wr_ctl[p].we && !wr_ctl[p].cancel &&
						wr_ctl[p].addr == frf_pkg::freg_idx_t'(g)) begin
					merged = merged | wr_data[p];
					touched = 1'b1;
				end
			end
			if (touched) begin
				model_regs[g] = merged;
			end
		end
	end
endtask

`endif

// ==== test/tb_frf.sv ====
// testbench for the register file top with reference model, compare process and timeout.

`timescale 1ns/1ns

module tb_frf;

	localparam int tb_flen = 64;
	localparam int tb_num_read = 4;
	localparam int tb_num_write = 3;

	// run length, used for the timeout.
	localparam int reset_cycles = 5;
	localparam int directed_cycles = 80;
	localparam int random_cycles = 400;
	localparam int stim_cycles = reset_cycles + directed_cycles + random_cycles;
	localparam int timeout_cycles = 2 * stim_cycles;

	logic                  core_clk;
	logic                  rst;
	logic                  rf_init;
	frf_pkg::freg_wr_ctl_t wr_ctl [tb_num_write];
	logic [tb_flen-1:0]    wr_data [tb_num_write];
	frf_pkg::freg_idx_t    rd_addr [tb_num_read];
	logic [tb_flen-1:0]    rd_data [tb_num_read];
	int                    cycle_count;

	`include "tb_frf_model.svh"

	frf_top #(
		.flen      (tb_flen),
		.num_read  (tb_num_read),
		.num_write (tb_num_write)
	) uut (
		.core_clk (core_clk),
		.rst      (rst),
		.rf_init  (rf_init),
		.wr_ctl   (wr_ctl),
		.wr_data  (wr_data),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	always #50 core_clk = ~core_clk;

	always @(posedge core_clk) begin
		model_clock();
	end

	always @(posedge core_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("TEST FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic check_value(input logic [tb_flen-1:0] got,
			input logic [tb_flen-1:0] expected, input string what);
		if (got !== expected) begin
			$display("FAILED at %0t ns: %s read %h, expected %h", $time, what, got, expected);
			$display("TEST FAILED");
			$fatal(1, "stopping on first mismatch");
		end
	endtask

	// inputs move with nonblocking updates, so this sees the settled values.
	always @(negedge core_clk) begin
		if (!rst) begin
			for (int r = 0; r < tb_num_read; r++) begin
				check_value(rd_data[r], expected_read(rd_addr[r]),
					$sformatf("port %0d addr %0d", r, rd_addr[r]));
			end
		end
	end

	// wait for the falling edge and park the write ports.
	task automatic step_cycle();
		@(negedge core_clk);
		rf_init <= 1'b0;
		for (int p = 0; p < tb_num_write; p++) begin
			wr_ctl[p] <= '0;
			wr_data[p] <= '0;
		end
	endtask

	task automatic put_write(input int p, input logic en, input logic squash,
			input frf_pkg::freg_idx_t addr, input logic [tb_flen-1:0] data);
		wr_ctl[p].we <= en;
		wr_ctl[p].cancel <= squash;
		wr_ctl[p].addr <= addr;
		wr_data[p] <= data;
	endtask

	task automatic read_all(input frf_pkg::freg_idx_t addr);
		for (int r = 0; r < tb_num_read; r++) begin
			rd_addr[r] <= addr;
		end
	endtask

	// every read port must show the same value.
	task automatic expect_all(input logic [tb_flen-1:0] value, input string what);
		for (int r = 0; r < tb_num_read; r++) begin
			check_value(rd_data[r], value, $sformatf("%s, port %0d", what, r));
		end
	endtask

	task automatic random_traffic(input int cycles);
		logic [31:0] r;
		logic [31:0] s;
		frf_pkg::freg_idx_t addr;
		for (int n = 0; n < cycles; n++) begin
			step_cycle();
			for (int p = 0; p < tb_num_write; p++) begin
				r = next_rand();
				// half the writes aim at regs 0 to 7 to force collisions.
				addr = r[27] ? {2'b00, r[2:0]} : r[20:16];
				put_write(p, r[31], r[30:29] == 2'b00, addr, {next_rand(), next_rand()});
			end
			s = next_rand();
			rf_init <= (s[9:5] == 5'd0);
			for (int k = 0; k < tb_num_read; k++) begin
				s = next_rand();
				rd_addr[k] <= s[22:18];
			end
		end
	endtask

	initial begin
		core_clk = 1'b0;
		rst = 1'b1;
		rf_init = 1'b0;
		cycle_count = 0;
		for (int p = 0; p < tb_num_write; p++) begin
			wr_ctl[p] = '0;
			wr_data[p] = '0;
		end
		for (int r = 0; r < tb_num_read; r++) begin
			rd_addr[r] = '0;
		end
		repeat (reset_cycles) @(posedge core_clk);
		@(negedge core_clk);
		rst <= 1'b0;

		// every port walks all 32 addresses after the clear.
		for (int a = 0; a < frf_pkg::FREG_NUM; a++) begin
			step_cycle();
			for (int r = 0; r < tb_num_read; r++) begin
				rd_addr[r] <= frf_pkg::freg_idx_t'((a + r * 8) % frf_pkg::FREG_NUM);
			end
		end
		step_cycle();
		expect_all('0, "after reset");

		// one write per port, seen on all ports one cycle later.
		for (int p = 0; p < tb_num_write; p++) begin
			put_write(p, 1'b1, 1'b0, frf_pkg::freg_idx_t'(p + 1),
				64'h1111_0000_0000_0001 * (p + 1));
			read_all(frf_pkg::freg_idx_t'(p + 1));
			step_cycle();
			step_cycle();
			expect_all(64'h1111_0000_0000_0001 * (p + 1), "single write");
		end

		// squashed and disabled writes leave reg 1 alone.
		put_write(0, 1'b1, 1'b1, 5'd1, 64'hdead_beef_dead_beef);
		put_write(1, 1'b0, 1'b0, 5'd1, 64'hcafe_f00d_cafe_f00d);
		read_all(5'd1);
		step_cycle();
		step_cycle();
		expect_all(64'h1111_0000_0000_0001, "cancelled write");

		// three writes to different registers in one cycle.
		put_write(0, 1'b1, 1'b0, 5'd10, 64'h0a0a_0a0a_0a0a_0a0a);
		put_write(1, 1'b1, 1'b0, 5'd11, 64'h0b0b_0b0b_0b0b_0b0b);
		put_write(2, 1'b1, 1'b0, 5'd12, 64'h0c0c_0c0c_0c0c_0c0c);
		rd_addr[0] <= 5'd10;
		rd_addr[1] <= 5'd11;
		rd_addr[2] <= 5'd12;
		rd_addr[3] <= 5'd10;
		step_cycle();
		step_cycle();
		check_value(rd_data[0], 64'h0a0a_0a0a_0a0a_0a0a, "parallel write reg 10");
		check_value(rd_data[1], 64'h0b0b_0b0b_0b0b_0b0b, "parallel write reg 11");
		check_value(rd_data[2], 64'h0c0c_0c0c_0c0c_0c0c, "parallel write reg 12");

		// two-way then three-way collision on reg 20.
		put_write(0, 1'b1, 1'b0, 5'd20, 64'h0000_0000_00f0_0001);
		put_write(2, 1'b1, 1'b0, 5'd20, 64'h0300_0000_0000_0010);
		read_all(5'd20);
		step_cycle();
		step_cycle();
		expect_all(64'h0300_0000_00f0_0011, "two-way merge");
		put_write(0, 1'b1, 1'b0, 5'd20, 64'h8000_0000_0000_0000);
		put_write(1, 1'b1, 1'b0, 5'd20, 64'h0000_0001_0000_0000);
		put_write(2, 1'b1, 1'b0, 5'd20, 64'h0000_0000_0000_0004);
		step_cycle();
		step_cycle();
		expect_all(64'h8000_0001_0000_0004, "three-way merge");

		// rf_init clears all but the register written beside it.
		put_write(0, 1'b1, 1'b0, 5'd4, 64'h4444_4444_4444_4444);
		put_write(1, 1'b1, 1'b0, 5'd5, 64'h5555_5555_5555_5555);
		put_write(2, 1'b1, 1'b0, 5'd6, 64'h6666_6666_6666_6666);
		step_cycle();
		rf_init <= 1'b1;
		put_write(1, 1'b1, 1'b0, 5'd5, 64'h0123_4567_89ab_cdef);
		rd_addr[0] <= 5'd4;
		rd_addr[1] <= 5'd5;
		rd_addr[2] <= 5'd6;
		rd_addr[3] <= 5'd20;
		step_cycle();
		step_cycle();
		check_value(rd_data[0], '0, "init clears reg 4");
		check_value(rd_data[1], 64'h0123_4567_89ab_cdef, "init keeps written reg 5");
		check_value(rd_data[2], '0, "init clears reg 6");
		check_value(rd_data[3], '0, "init clears reg 20");

		random_traffic(random_cycles);
		step_cycle();
		step_cycle();
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+test
src/frf_pkg.sv
src/frf_write_merge.sv
src/frf_storage.sv
src/frf_top.sv
test/tb_frf.sv
